/* verilog/uart_pkg.sv */
package uart_pkg;

  // frame format, fixed at 8N1
  localparam int DATA_BITS  = 8;
  localparam int OVERSAMPLE = 16; // ticks per bit
  localparam int STOP_TICKS = 16;

  // 50 MHz clock into a 16x strobe for 115200 baud
  localparam int BAUD_DIV = 27;

  typedef logic [DATA_BITS-1:0] data_t;

  // position inside one bit, counted in ticks
  typedef logic [3:0] tick_cnt_t;

  // index of the data bit being sent or received
  typedef logic [2:0] bit_cnt_t;

  typedef enum logic [1:0]
  {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0]
  {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

/* verilog/baud_tick_gen.sv */
`timescale 1ns/10ps

module baud_tick_gen
  import uart_pkg::*;
(
  input  logic clk,
  input  logic reset,
  output logic s_tick
);

  logic [$clog2(BAUD_DIV)-1:0] cnt;
  logic                        wrap;

  assign wrap = (cnt == BAUD_DIV - 1);

  // free running, so both serial engines see the same tick phase
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      cnt <= '0;
    end
    else if (wrap)
    begin
      cnt <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  assign s_tick = wrap; // one cycle wide, every BAUD_DIV clocks

endmodule

/* verilog/tx_fifo.sv */
`timescale 1ns/10ps

module tx_fifo
  import uart_pkg::*;
#(
  parameter int DEPTH = 8
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  wr,
  input  data_t wr_data,
  input  logic  rd,
  output data_t rd_data,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  data_t             mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_wr;
  logic              do_rd;

  assign do_wr = wr && !full; // writes into a full FIFO are dropped
  assign do_rd = rd && !empty;

  always_ff @(posedge clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap at DEPTH so any depth works, not only powers of two
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither leave the level alone
      endcase
    end
  end

  assign rd_data = mem[rd_ptr]; // head entry, shown without a read
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  s_tick,
  input  logic  empty,
  input  data_t rd_data,
  output logic  rd,
  output logic  tx
);

  tx_state_t state_reg, state_next;
  tick_cnt_t s_reg, s_next;
  bit_cnt_t  n_reg, n_next;
  data_t     b_reg, b_next;
  logic      tx_reg, tx_next;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state_reg <= TX_IDLE;
      s_reg     <= '0;
      n_reg     <= '0;
      tx_reg    <= 1'b1; // line idles high
    end
    else
    begin
      state_reg <= state_next;
      s_reg     <= s_next;
      n_reg     <= n_next;
      tx_reg    <= tx_next;
    end
  end

  always_ff @(posedge clk)
  begin
    b_reg <= b_next;
  end

  // tx_next is set on each transition, so the registered line changes
  // on the same edge as the state and no cycle is lost on the wire
  always_comb
  begin
    state_next = state_reg;
    s_next     = s_reg;
    n_next     = n_reg;
    b_next     = b_reg;
    tx_next    = tx_reg;
    rd         = 1'b0;
    case (state_reg)
      TX_IDLE:
      begin
        tx_next = 1'b1;
        if (!empty)
        begin
          rd         = 1'b1; // pop and capture in the same cycle
          b_next     = rd_data;
          s_next     = '0;
          tx_next    = 1'b0;
          state_next = TX_START;
        end
      end
      TX_START:
      begin
        if (s_tick)
        begin
          if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
          begin
            s_next     = '0;
            n_next     = '0;
            tx_next    = b_reg[0];
            state_next = TX_DATA;
          end
          else
            s_next = s_reg + 1'b1;
        end
      end
      TX_DATA:
      begin
        if (s_tick)
        begin
          if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
          begin
            s_next = '0;
            b_next = b_reg >> 1;
            if (n_reg == bit_cnt_t'(DATA_BITS - 1))
            begin
              tx_next    = 1'b1; // stop bit
              state_next = TX_STOP;
            end
            else
            begin
              n_next  = n_reg + 1'b1;
              tx_next = b_reg[1];
            end
          end
          else
            s_next = s_reg + 1'b1;
        end
      end
      TX_STOP:
      begin
        if (s_tick)
        begin
          if (s_reg == tick_cnt_t'(STOP_TICKS - 1))
            state_next = TX_IDLE;
          else
            s_next = s_reg + 1'b1;
        end
      end
      default: state_next = TX_IDLE;
    endcase
  end

  assign tx = tx_reg;

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx
  import uart_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  s_tick,
  input  logic  rx,
  output data_t rx_data,
  output logic  rx_done_tick,
  output logic  rx_frame_err
);

  rx_state_t state_reg, state_next;
  tick_cnt_t s_reg, s_next;
  bit_cnt_t  n_reg, n_next;
  data_t     b_reg, b_next;
  logic      rx_meta;
  logic      rx_sync;
  logic      rx_prev;
  logic      rx_fall;

  // rx is asynchronous to clk
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_fall = rx_prev && !rx_sync;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state_reg <= RX_IDLE;
      s_reg     <= '0;
      n_reg     <= '0;
    end
    else
    begin
      state_reg <= state_next;
      s_reg     <= s_next;
      n_reg     <= n_next;
    end
  end

  always_ff @(posedge clk)
  begin
    b_reg <= b_next;
  end

  always_comb
  begin
    state_next   = state_reg;
    s_next       = s_reg;
    n_next       = n_reg;
    b_next       = b_reg;
    rx_done_tick = 1'b0;
    rx_frame_err = 1'b0;
    case (state_reg)
      RX_IDLE:
      begin
        if (rx_fall)
        begin
          s_next     = '0;
          state_next = RX_START;
        end
      end
      RX_START:
      begin
        if (s_tick)
        begin
          // half a bit in, the line must still be low
          if (s_reg == tick_cnt_t'(OVERSAMPLE / 2 - 1))
          begin
            s_next     = '0;
            n_next     = '0;
            state_next = rx_sync ? RX_IDLE : RX_DATA;
          end
          else
            s_next = s_reg + 1'b1;
        end
      end
      RX_DATA:
      begin
        if (s_tick)
        begin
          if (s_reg == tick_cnt_t'(OVERSAMPLE - 1))
          begin
            s_next = '0;
            b_next = {rx_sync, b_reg[DATA_BITS-1:1]}; // LSB arrives first
            if (n_reg == bit_cnt_t'(DATA_BITS - 1))
              state_next = RX_STOP;
            else
              n_next = n_reg + 1'b1;
          end
          else
            s_next = s_reg + 1'b1;
        end
      end
      RX_STOP:
      begin
        if (s_tick)
        begin
          if (s_reg == tick_cnt_t'(STOP_TICKS - 1))
          begin
            rx_done_tick = 1'b1;
            rx_frame_err = !rx_sync; // stop bit seen low at its centre
            state_next   = RX_IDLE;
          end
          else
            s_next = s_reg + 1'b1;
        end
      end
      default: state_next = RX_IDLE;
    endcase
  end

  assign rx_data = b_reg;

endmodule

/* verilog/uart_top.sv */
`timescale 1ns/10ps

module uart_top
  import uart_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  wr,
  input  data_t wr_data,
  output logic  tx_full,
  output logic  tx,
  input  logic  rx,
  output data_t rx_data,
  output logic  rx_done_tick,
  output logic  rx_frame_err
);

  logic  s_tick;
  logic  fifo_empty;
  logic  fifo_rd;
  data_t fifo_rd_data;

  baud_tick_gen baud_tick_gen_inst
  (
    .clk    (clk),
    .reset  (reset),
    .s_tick (s_tick)
  );

  // host writes queue here while a frame is on the line
  tx_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) tx_fifo_inst
  (
    .clk     (clk),
    .reset   (reset),
    .wr      (wr),
    .wr_data (wr_data),
    .rd      (fifo_rd),
    .rd_data (fifo_rd_data),
    .empty   (fifo_empty),
    .full    (tx_full)
  );

  uart_tx uart_tx_inst
  (
    .clk     (clk),
    .reset   (reset),
    .s_tick  (s_tick),
    .empty   (fifo_empty),
    .rd_data (fifo_rd_data),
    .rd      (fifo_rd),
    .tx      (tx)
  );

  uart_rx uart_rx_inst
  (
    .clk          (clk),
    .reset        (reset),
    .s_tick       (s_tick),
    .rx           (rx),
    .rx_data      (rx_data),
    .rx_done_tick (rx_done_tick),
    .rx_frame_err (rx_frame_err)
  );

endmodule

/* tb/uart_top_tb.sv */
`timescale 1ns/10ps

module uart_top_tb
  import uart_pkg::*;
();

  localparam int FIFO_DEPTH  = 8;
  localparam int BIT_CYCLES  = OVERSAMPLE * BAUD_DIV;
  localparam int FRAME_TICKS = 10 * OVERSAMPLE;

  // waveform, single byte with its idle window, burst plus drain window,
  // two bit-banged frames with idle bits, glitch window
  localparam int NUM_FRAMES     = 1 + 3 + (FIFO_DEPTH + 3) + 3 + 1;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_TICKS * BAUD_DIV * 5 / 4;

  logic       clk;
  logic       reset;
  logic       wr;
  data_t      wr_data;
  logic       tx_full;
  logic       tx;
  logic       rx;
  data_t      rx_data;
  logic       rx_done_tick;
  logic       rx_frame_err;
  logic       loop_en;
  logic       rx_drv;
  logic [8:0] rx_q [$]; // {frame error, data} per received byte
  int         errors;
  int         checks;
  int         cycles = 0;
  integer     seed;

  assign rx = loop_en ? tx : rx_drv;

  uart_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uart_top_inst
  (
    .clk          (clk),
    .reset        (reset),
    .wr           (wr),
    .wr_data      (wr_data),
    .tx_full      (tx_full),
    .tx           (tx),
    .rx           (rx),
    .rx_data      (rx_data),
    .rx_done_tick (rx_done_tick),
    .rx_frame_err (rx_frame_err)
  );

  always #10 clk = ~clk;

  always @(negedge clk)
  begin
    if (!reset && rx_done_tick)
      rx_q.push_back({rx_frame_err, rx_data});
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a test did not complete", cycles);
      $display("%0d checks, %0d errors", checks, errors);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic write_burst(input data_t bytes [$]);
    foreach (bytes[i])
    begin
      @(posedge clk);
      wr      <= 1'b1;
      wr_data <= bytes[i];
    end
    @(posedge clk);
    wr <= 1'b0;
  endtask

  task automatic receive_and_check(input data_t exp_data, input logic exp_err);
    int         n;
    logic [8:0] entry;
    n = 0;
    while (rx_q.size() == 0 && n < 2 * FRAME_TICKS * BAUD_DIV)
    begin
      @(negedge clk);
      n++;
    end
    if (rx_q.size() == 0)
      report_failure("no byte was received within two frame times");
    else
    begin
      entry = rx_q.pop_front();
      check_data("rx_data", entry[7:0], exp_data);
      check_bit("rx_frame_err", entry[8], exp_err);
    end
  endtask

  task automatic expect_no_rx(input int wait_cycles, input string what);
    repeat (wait_cycles) @(negedge clk);
    if (rx_q.size() != 0)
    begin
      report_failure(what);
      rx_q.delete();
    end
  endtask

  // serial line model, called right after a rising edge
  task automatic send_bit(input logic value);
    rx_drv <= value;
    repeat (BIT_CYCLES) @(posedge clk);
  endtask

  task automatic send_frame(input data_t d, input logic stop);
    @(posedge clk);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++)
      send_bit(d[i]);
    send_bit(stop);
    send_bit(1'b1); // one idle bit so the next start edge is clean
  endtask

  task automatic reset_and_idle();
    repeat (8)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("tx_full", tx_full, 1'b0);
    end
    @(posedge clk);
    reset   <= 1'b0;
    loop_en <= 1'b1;
    repeat (200)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("tx_full", tx_full, 1'b0);
      check_bit("rx_done_tick", rx_done_tick, 1'b0);
    end
  endtask

  task automatic sample_tx_waveform();
    data_t d;
    int    n;
    d = data_t'($random(seed));
    write_burst('{d});
    n = 0;
    while (tx !== 1'b0 && n < 4 * BAUD_DIV)
    begin
      @(negedge clk);
      n++;
    end
    if (tx !== 1'b0)
      report_failure("tx did not fall after a write into an empty FIFO");
    else
    begin
      repeat (BIT_CYCLES / 2) @(negedge clk); // centre of the start bit
      check_bit("tx start bit", tx, 1'b0);
      for (int i = 0; i < 8; i++)
      begin
        repeat (BIT_CYCLES) @(negedge clk);
        check_bit($sformatf("tx data bit %0d", i), tx, d[i]);
      end
      repeat (BIT_CYCLES) @(negedge clk);
      check_bit("tx stop bit", tx, 1'b1);
    end
    receive_and_check(d, 1'b0);
  endtask

  task automatic loop_back_one_byte();
    data_t d;
    d = data_t'($random(seed));
    write_burst('{d});
    receive_and_check(d, 1'b0);
    // a repeated frame would end about one frame time after the first
    expect_no_rx(3 * FRAME_TICKS * BAUD_DIV / 2,
                 "a single written byte was received twice");
  endtask

  task automatic burst_with_overflow();
    data_t sent [$];
    data_t extra [$];
    for (int i = 0; i < FIFO_DEPTH + 1; i++)
      sent.push_back(data_t'($random(seed)));
    for (int i = 0; i < 3; i++)
      extra.push_back(data_t'($random(seed)));
    write_burst(sent);
    @(negedge clk);
    check_bit("tx_full", tx_full, 1'b1); // first byte already on the line
    write_burst(extra);
    foreach (sent[i])
      receive_and_check(sent[i], 1'b0);
    expect_no_rx(3 * FRAME_TICKS * BAUD_DIV / 2,
                 "a byte written while the FIFO was full was sent");
  endtask

  task automatic inject_frame_error();
    data_t d;
    @(posedge clk);
    loop_en <= 1'b0;
    d = data_t'($random(seed));
    send_frame(d, 1'b0);
    receive_and_check(d, 1'b1);
    d = data_t'($random(seed));
    send_frame(d, 1'b1);
    receive_and_check(d, 1'b0);
  endtask

  task automatic reject_start_glitch();
    @(posedge clk);
    rx_drv <= 1'b0;
    repeat (3 * BAUD_DIV) @(posedge clk); // under 4 ticks low
    rx_drv <= 1'b1;
    expect_no_rx(FRAME_TICKS * BAUD_DIV, "a short low pulse on rx was taken as a start bit");
  endtask

  initial
  begin
    clk     = 1'b0;
    reset   = 1'b1;
    wr      = 1'b0;
    wr_data = '0;
    loop_en = 1'b0;
    rx_drv  = 1'b1;
    errors  = 0;
    checks  = 0;
    seed    = 32'hccd5877d;
    reset_and_idle();
    sample_tx_waveform();
    loop_back_one_byte();
    burst_with_overflow();
    inject_frame_error();
    reject_start_glitch();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* uart_top.f */
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/tx_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
tb/uart_top_tb.sv

/* Bender.yml */
package:
  name: uart_top

sources:
  - files:
      - verilog/uart_pkg.sv
      - verilog/baud_tick_gen.sv
      - verilog/tx_fifo.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/uart_top.sv
  - target: test
    files:
      - tb/uart_top_tb.sv
